/* Bender.yml */
package:
  name: rename_subsystem

export_include_dirs:
  - .

sources:
  - files:
      - rename_pkg.sv
      - rat.sv
      - free_list.sv
      - rename_stage.sv
      - rename_top.sv
  - target: simulation
    files:
      - rename_tb.sv

/* free_list.sv */
`timescale 1ns/100ps
`include "rename_defines.svh"

module free_list (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pop,
    input  logic                 push,
    input  rename_pkg::phy_idx_t push_phy,
    output rename_pkg::phy_idx_t head_phy,
    output logic                 empty,
    output logic                 filling
);

    import rename_pkg::*;

    phy_idx_t           buffer [`PRF_DEPTH];
    phy_idx_t           head;
    phy_idx_t           tail;
    logic [`PRF_IDX:0]  count;   // one bit wider so a full list is representable
    fl_state_e          state;
    phy_idx_t           fill_idx;
    logic               wr_en;
    phy_idx_t           wr_data;

    assign filling = (state == IDLE_FILL);

    // the fill sequencer owns the write port until every free index is loaded
    assign wr_en   = filling || push;
    assign wr_data = filling ? fill_idx : push_phy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE_FILL;
            fill_idx <= phy_idx_t'(`ARF_DEPTH);
        end else if (filling) begin
            fill_idx <= fill_idx + 1'b1;
            if (fill_idx == phy_idx_t'(`PRF_DEPTH - 1)) begin
                state <= RUN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + wr_en - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            buffer[tail] <= wr_data;
        end
    end

    assign head_phy = buffer[head];

    // no push to pop bypass so a just-retired index waits one cycle
    assign empty = (count == '0) || filling;

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !empty
    );

    // retire can only return what rename handed out
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= `PRF_DEPTH
    );

endmodule

/* list.f */
+incdir+.
rename_pkg.sv
rat.sv
free_list.sv
rename_stage.sv
rename_top.sv
rename_tb.sv

/* rat.sv */
`timescale 1ns/100ps
`include "rename_defines.svh"

module rat (
    input  logic                   clk,
    input  logic                   rst,
    input  rename_pkg::arch_idx_t  rs1,
    input  rename_pkg::arch_idx_t  rs2,
    input  logic                   wr_en,
    input  rename_pkg::arch_idx_t  wr_arch,
    input  rename_pkg::phy_idx_t   wr_phy,
    input  rename_pkg::cdb_entry_t cdb [`CDB_WIDTH],
    output rename_pkg::phy_idx_t   rs1_phy,
    output rename_pkg::phy_idx_t   rs2_phy,
    output logic                   rs1_ready,
    output logic                   rs2_ready,
    output rename_pkg::phy_idx_t   rd_old_phy
);

    import rename_pkg::*;

    phy_idx_t              map [`ARF_DEPTH];
    logic [`ARF_DEPTH-1:0] ready;
    logic [`CDB_WIDTH-1:0] cdb_hit;

    // a broadcast only counts if its producer is still the current mapping
    always_comb begin
        for (int i = 0; i < `CDB_WIDTH; i++) begin
            cdb_hit[i] = cdb[i].valid && (map[cdb[i].rd_arch] == cdb[i].rd_phy);
        end
    end

    function automatic logic src_ready(arch_idx_t idx);
        logic rdy;
        rdy = ready[idx];
        for (int i = 0; i < `CDB_WIDTH; i++) begin
            if (cdb_hit[i] && (cdb[i].rd_arch == idx)) begin
                rdy = 1'b1;   // same-cycle wakeup
            end
        end
        return rdy || (idx == '0);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARF_DEPTH; i++) begin
                map[i]   <= phy_idx_t'(i);   // identity mapping, all committed
                ready[i] <= 1'b1;
            end
        end else begin
            for (int i = 0; i < `CDB_WIDTH; i++) begin
                if (cdb_hit[i]) begin
                    ready[cdb[i].rd_arch] <= 1'b1;
                end
            end
            if (wr_en) begin
                map[wr_arch]   <= wr_phy;
                ready[wr_arch] <= 1'b0;   // new producer has not written back yet
            end
        end
    end

    always_comb begin
        rs1_phy    = (rs1 == '0) ? '0 : map[rs1];
        rs2_phy    = (rs2 == '0) ? '0 : map[rs2];
        rs1_ready  = src_ready(rs1);
        rs2_ready  = src_ready(rs2);
        rd_old_phy = map[wr_arch];   // read before the write lands at the edge
    end

    // x0 is hardwired so the rename stage must never remap it
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (wr_arch != '0)
    );

endmodule

/* rename_defines.svh */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file size
`define ARF_DEPTH 32

// physical register file size
`define PRF_DEPTH 64

// number of CDB broadcast ports
`define CDB_WIDTH 2

// index widths
`define ARF_IDX 5
`define PRF_IDX 6

`endif

/* rename_pkg.sv */
package rename_pkg;

`include "rename_defines.svh"

    typedef logic [`ARF_IDX-1:0] arch_idx_t;
    typedef logic [`PRF_IDX-1:0] phy_idx_t;

    // only KIND_REG produces a destination register
    typedef enum logic [1:0] {
        KIND_REG    = 2'd0,
        KIND_STORE  = 2'd1,
        KIND_BRANCH = 2'd2
    } inst_kind_e;

    typedef struct packed {
        inst_kind_e kind;
        arch_idx_t  rs1;
        arch_idx_t  rs2;
        arch_idx_t  rd;
        logic       tag;   // passed through untouched
    } decode_req_t;

    typedef struct packed {
        logic      valid;
        arch_idx_t rd_arch;
        phy_idx_t  rd_phy;
    } cdb_entry_t;

    typedef struct packed {
        inst_kind_e kind;
        phy_idx_t   rs1_phy;
        logic       rs1_ready;
        phy_idx_t   rs2_phy;
        logic       rs2_ready;
        logic       rd_writes;
        phy_idx_t   rd_phy;
        phy_idx_t   old_rd_phy;
        arch_idx_t  rd_arch;
        logic       tag;
    } rename_out_t;

    typedef enum logic {
        IDLE_FILL = 1'b0,
        RUN       = 1'b1
    } fl_state_e;

endpackage

/* rename_stage.sv */
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dec_valid,
    input  rename_pkg::decode_req_t dec,
    input  logic                    hold,
    input  rename_pkg::cdb_entry_t  cdb [`CDB_WIDTH],
    input  logic                    retire_valid,
    input  rename_pkg::phy_idx_t    retire_phy,
    output logic                    stall,
    output logic                    ren_valid,
    output rename_pkg::rename_out_t ren
);

    import rename_pkg::*;

    logic        needs_reg;
    logic        accept;
    logic        alloc;
    phy_idx_t    rs1_phy;
    phy_idx_t    rs2_phy;
    logic        rs1_ready;
    logic        rs2_ready;
    phy_idx_t    rd_old_phy;
    phy_idx_t    head_phy;
    logic        fl_empty;
    logic        fl_filling;
    rename_out_t ren_next;

    assign needs_reg = (dec.kind == KIND_REG) && (dec.rd != '0);

    assign stall  = hold || fl_filling || (needs_reg && fl_empty);
    assign accept = dec_valid && !stall;
    assign alloc  = accept && needs_reg;

    rat u_rat (
        .clk        (clk),
        .rst        (rst),
        .rs1        (dec.rs1),
        .rs2        (dec.rs2),
        .wr_en      (alloc),
        .wr_arch    (dec.rd),
        .wr_phy     (head_phy),
        .cdb        (cdb),
        .rs1_phy    (rs1_phy),
        .rs2_phy    (rs2_phy),
        .rs1_ready  (rs1_ready),
        .rs2_ready  (rs2_ready),
        .rd_old_phy (rd_old_phy)
    );

    free_list u_free_list (
        .clk      (clk),
        .rst      (rst),
        .pop      (alloc),
        .push     (retire_valid),
        .push_phy (retire_phy),
        .head_phy (head_phy),
        .empty    (fl_empty),
        .filling  (fl_filling)
    );

    always_comb begin
        ren_next.kind       = dec.kind;
        ren_next.rs1_phy    = rs1_phy;
        ren_next.rs1_ready  = rs1_ready;
        ren_next.rs2_phy    = rs2_phy;
        ren_next.rs2_ready  = rs2_ready;
        ren_next.rd_writes  = needs_reg;
        ren_next.rd_phy     = needs_reg ? head_phy : '0;    // zero when nothing is allocated
        ren_next.old_rd_phy = needs_reg ? rd_old_phy : '0;
        ren_next.rd_arch    = dec.rd;
        ren_next.tag        = dec.tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ren_valid <= 1'b0;
        end else begin
            ren_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ren <= ren_next;
        end
    end

    // the free list must never hand out the mapping that is being displaced
    a_fresh_rd_phy: assert property (
        @(posedge clk) disable iff (rst)
        alloc |-> (head_phy != rd_old_phy)
    );

endmodule

/* rename_tb.sv */
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_tb;

    import rename_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int FILL_CYCLES  = `PRF_DEPTH - `ARF_DEPTH;
    localparam int N_DIRECTED   = 96;   // read sweep, allocation, CDB, exhaustion and hold
    localparam int N_RAND       = 64;
    localparam int TEST_CYCLES  = RESET_CYCLES + FILL_CYCLES + N_DIRECTED + N_RAND;
    localparam int MARGIN       = 100;

    logic        clk;
    logic        rst;
    logic        dec_valid;
    decode_req_t dec;
    logic        hold;
    cdb_entry_t  cdb [`CDB_WIDTH];
    logic        retire_valid;
    phy_idx_t    retire_phy;
    logic        stall;
    logic        ren_valid;
    rename_out_t ren;

    // what the next cycle drives onto the DUT
    logic        drv_valid;
    decode_req_t drv_dec;
    logic        drv_hold;
    cdb_entry_t  drv_cdb [`CDB_WIDTH];
    logic        drv_retire;
    phy_idx_t    drv_retire_phy;

    phy_idx_t              map_m [`ARF_DEPTH];
    logic [`ARF_DEPTH-1:0] rdy_m;
    phy_idx_t              free_q [$];
    phy_idx_t              old_q [$];   // displaced mappings that may be retired

    logic        pend_valid;
    rename_out_t pend_ren;
    rename_out_t last_ren;
    logic        have_last;
    logic        checking;
    logic        tag_bit;
    int          errors;
    int          seed;

    rename_top DUT (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec          (dec),
        .hold         (hold),
        .cdb          (cdb),
        .retire_valid (retire_valid),
        .retire_phy   (retire_phy),
        .stall        (stall),
        .ren_valid    (ren_valid),
        .ren          (ren)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 8);
        $display("timeout: the run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display("Errors found");
        $fatal(1);
    end

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch stall: got %h expected %h at %0t", got, exp, $time));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch ren_valid: got %h expected %h at %0t",
                                     got, exp, $time));
        end
    endtask

    task automatic check_ren(input rename_out_t got, input rename_out_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch ren: got %h expected %h at %0t", got, exp, $time));
        end
    endtask

    function automatic int rand_range(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic arch_idx_t rand_arch();
        return arch_idx_t'(rand_range(`ARF_DEPTH));
    endfunction

    function automatic decode_req_t make_inst(input inst_kind_e k, input int rs1, input int rs2,
                                              input int rd);
        decode_req_t d;
        d.kind  = k;
        d.rs1   = arch_idx_t'(rs1);
        d.rs2   = arch_idx_t'(rs2);
        d.rd    = arch_idx_t'(rd);
        d.tag   = tag_bit;
        tag_bit = ~tag_bit;
        return d;
    endfunction

    function automatic logic writes_rd(input decode_req_t d);
        return (d.kind == KIND_REG) && (d.rd != '0);
    endfunction

    // a broadcast wakes an entry only while its producer is still mapped
    task automatic apply_cdb();
        for (int i = 0; i < `CDB_WIDTH; i++) begin
            if (drv_cdb[i].valid && (map_m[drv_cdb[i].rd_arch] == drv_cdb[i].rd_phy)) begin
                rdy_m[drv_cdb[i].rd_arch] = 1'b1;
            end
        end
    endtask

    function automatic rename_out_t ref_rename(input decode_req_t d);
        rename_out_t r;
        r.kind       = d.kind;
        r.rs1_phy    = (d.rs1 == '0) ? '0 : map_m[d.rs1];
        r.rs1_ready  = (d.rs1 == '0) || rdy_m[d.rs1];
        r.rs2_phy    = (d.rs2 == '0) ? '0 : map_m[d.rs2];
        r.rs2_ready  = (d.rs2 == '0) || rdy_m[d.rs2];
        r.rd_writes  = writes_rd(d);
        r.rd_phy     = '0;
        r.old_rd_phy = '0;
        if (r.rd_writes) begin
            r.rd_phy     = free_q.pop_front();
            r.old_rd_phy = map_m[d.rd];
            map_m[d.rd]  = r.rd_phy;
            rdy_m[d.rd]  = 1'b0;
        end
        r.rd_arch = d.rd;
        r.tag     = d.tag;
        return r;
    endfunction

    task automatic run_cycle(output logic accepted);
        logic exp_stall;
        @(posedge clk);
        #1;
        dec_valid = drv_valid;
        dec       = drv_dec;
        hold      = drv_hold;
        for (int i = 0; i < `CDB_WIDTH; i++) begin
            cdb[i] = drv_cdb[i];
        end
        retire_valid = drv_retire;
        retire_phy   = drv_retire_phy;
        #3;
        exp_stall = drv_hold || (writes_rd(drv_dec) && (free_q.size() == 0));
        check_stall(stall, exp_stall);
        accepted = drv_valid && !exp_stall;
        apply_cdb();   // ahead of the rename so the sources see a same-cycle wakeup
        if (accepted) begin
            pend_ren = ref_rename(drv_dec);
            if (pend_ren.rd_writes) begin
                old_q.push_back(pend_ren.old_rd_phy);
            end
        end
        pend_valid = accepted;
        if (drv_retire) begin
            free_q.push_back(drv_retire_phy);   // poppable from the next cycle on
        end
        for (int i = 0; i < `CDB_WIDTH; i++) begin
            drv_cdb[i].valid = 1'b0;
        end
        drv_retire = 1'b0;
    endtask

    task automatic issue(input decode_req_t d);
        logic acc;
        int   tries;
        acc       = 1'b0;
        tries     = 0;
        drv_valid = 1'b1;
        drv_dec   = d;
        while (!acc) begin
            if (tries == 40) begin
                report_failure("an instruction was never accepted by the rename stage");
            end
            run_cycle(acc);
            tries++;
        end
        drv_valid = 1'b0;
    endtask

    task automatic set_cdb(input int port, input arch_idx_t arch, input phy_idx_t phy);
        drv_cdb[port].valid   = 1'b1;
        drv_cdb[port].rd_arch = arch;
        drv_cdb[port].rd_phy  = phy;
    endtask

    // ren_valid is checked one cycle after each modeled acceptance
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (checking) begin
                check_valid(ren_valid, pend_valid);
                if (pend_valid) begin
                    check_ren(ren, pend_ren);
                    last_ren  = pend_ren;
                    have_last = 1'b1;
                end else if (have_last) begin
                    check_ren(ren, last_ren);   // fields hold between pulses
                end
                pend_valid = 1'b0;
            end
        end
    end

    initial begin
        logic     acc;
        int       wait_cnt;
        phy_idx_t stale;
        seed = 82;
        errors = 0;
        checking = 1'b0;
        pend_valid = 1'b0;
        have_last = 1'b0;
        tag_bit = 1'b0;
        rst = 1'b1;
        dec_valid = 1'b0;
        dec = '0;
        hold = 1'b0;
        retire_valid = 1'b0;
        retire_phy = '0;
        drv_valid = 1'b0;
        drv_dec = '0;
        drv_hold = 1'b0;
        drv_retire = 1'b0;
        drv_retire_phy = '0;
        for (int i = 0; i < `CDB_WIDTH; i++) begin
            cdb[i] = '0;
            drv_cdb[i] = '0;
        end
        for (int i = 0; i < `ARF_DEPTH; i++) begin
            map_m[i] = phy_idx_t'(i);
        end
        rdy_m = '1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        checking = 1'b1;

        wait_cnt = 0;
        @(negedge clk);
        while (stall === 1'b1) begin
            wait_cnt++;
            if (wait_cnt > 2 * FILL_CYCLES) begin
                report_failure("stall did not fall after the free list fill");
            end
            @(negedge clk);
        end
        check_stall(stall, 1'b0);
        if (wait_cnt != FILL_CYCLES) begin
            report_failure($sformatf("stall was high for %0d cycles after reset instead of %0d",
                                     wait_cnt, FILL_CYCLES));
        end
        for (int i = `ARF_DEPTH; i < `PRF_DEPTH; i++) begin
            free_q.push_back(phy_idx_t'(i));
        end

        // identity mapping seen through read-only instructions
        for (int i = 0; i < `ARF_DEPTH; i++) begin
            issue(make_inst(KIND_STORE, i, rand_arch(), 0));
        end
        issue(make_inst(KIND_BRANCH, 0, 0, 0));

        for (int i = 1; i <= 6; i++) begin
            issue(make_inst(KIND_REG, i, i + 1, i));
        end
        issue(make_inst(KIND_STORE, 1, 2, 5));
        issue(make_inst(KIND_BRANCH, 3, 4, 7));
        issue(make_inst(KIND_REG, 5, 6, 0));

        issue(make_inst(KIND_REG, 8, 9, 10));
        issue(make_inst(KIND_STORE, 10, 10, 0));

        issue(make_inst(KIND_REG, 1, 2, 11));
        set_cdb(0, 5'd11, map_m[11]);
        issue(make_inst(KIND_STORE, 11, 0, 0));
        issue(make_inst(KIND_STORE, 0, 11, 0));
        stale = map_m[11];
        issue(make_inst(KIND_REG, 0, 0, 11));
        set_cdb(1, 5'd11, stale);
        issue(make_inst(KIND_STORE, 11, 11, 0));

        while (free_q.size() > 0) begin
            issue(make_inst(KIND_REG, rand_arch(), rand_arch(), 1 + rand_range(31)));
        end
        drv_valid = 1'b1;
        drv_dec = make_inst(KIND_REG, 2, 3, 12);
        repeat (4) run_cycle(acc);
        for (int k = 0; k < 3; k++) begin
            drv_retire = 1'b1;
            drv_retire_phy = old_q.pop_front();
            run_cycle(acc);
            if (acc) begin
                drv_valid = 1'b0;
            end
        end
        issue(make_inst(KIND_REG, 12, 0, 14));
        issue(make_inst(KIND_REG, 14, 12, 15));

        for (int k = 0; k < 4; k++) begin
            drv_retire = 1'b1;
            drv_retire_phy = old_q.pop_front();
            run_cycle(acc);
        end
        drv_hold = 1'b1;
        drv_valid = 1'b1;
        drv_dec = make_inst(KIND_REG, 4, 5, 13);
        repeat (3) run_cycle(acc);
        drv_hold = 1'b0;
        run_cycle(acc);
        drv_valid = 1'b0;
        run_cycle(acc);

        acc = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            if (acc || !drv_valid) begin
                drv_valid = (rand_range(4) != 0);
                drv_dec = make_inst(inst_kind_e'(rand_range(3)), rand_arch(), rand_arch(),
                                    rand_arch());
            end
            drv_hold = (rand_range(8) == 0);
            if ((rand_range(2) == 0) && (old_q.size() > 0)) begin
                drv_retire = 1'b1;
                drv_retire_phy = old_q.pop_front();
            end
            for (int i = 0; i < `CDB_WIDTH; i++) begin
                if (rand_range(3) == 0) begin
                    stale = phy_idx_t'(rand_range(`PRF_DEPTH));
                    set_cdb(i, rand_arch(), stale);
                    if (rand_range(4) != 0) begin
                        drv_cdb[i].rd_phy = map_m[drv_cdb[i].rd_arch];
                    end
                end
            end
            run_cycle(acc);
        end
        drv_valid = 1'b0;
        drv_hold = 1'b0;
        repeat (2) run_cycle(acc);

        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* rename_top.sv */
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dec_valid,
    input  rename_pkg::decode_req_t dec,
    input  logic                    hold,
    input  rename_pkg::cdb_entry_t  cdb [`CDB_WIDTH],
    input  logic                    retire_valid,
    input  rename_pkg::phy_idx_t    retire_phy,
    output logic                    stall,
    output logic                    ren_valid,
    output rename_pkg::rename_out_t ren
);

    import rename_pkg::*;

    // boundary toward decode, dispatch, the CDB and retire
    decode_req_t dec_w;
    rename_out_t ren_w;

    assign dec_w = dec;
    assign ren   = ren_w;

    rename_stage u_rename_stage (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec          (dec_w),
        .hold         (hold),
        .cdb          (cdb),
        .retire_valid (retire_valid),
        .retire_phy   (retire_phy),
        .stall        (stall),
        .ren_valid    (ren_valid),
        .ren          (ren_w)
    );

endmodule
